//--- design/prf_pkg.sv
`default_nettype none

package prf_pkg;

    localparam int num_arch_regs = 32;
    localparam int num_phys_regs = 128;
    localparam int free_depth    = num_phys_regs - num_arch_regs; // tags 32..127 after reset
    localparam int mul_latency   = 3;                             // product pipeline stages

    typedef logic [$clog2(num_arch_regs)-1:0] arch_idx_t;
    typedef logic [$clog2(num_phys_regs)-1:0] phys_idx_t;
    typedef logic [$clog2(free_depth + 1)-1:0] free_ptr_t; // free list pointer and count
    typedef logic [31:0] word_t;

    typedef enum logic [3:0] {
        op_add  = 4'h0,
        op_addi = 4'h1,
        op_mul  = 4'h2
    } opcode_e;

    typedef struct packed {
        opcode_e     opcode;
        arch_idx_t   rd;
        arch_idx_t   rs1;
        arch_idx_t   rs2;
        logic [12:0] unused;
    } instr_r_t;

    typedef struct packed {
        opcode_e            opcode;
        arch_idx_t          rd;
        arch_idx_t          rs1;
        logic signed [17:0] imm;
    } instr_i_t;

    // one word, read as R or I format by opcode
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

    typedef struct packed {
        logic      unit_mul;
        arch_idx_t arch_rd;
        phys_idx_t phys_rd;
        phys_idx_t old_phys_rd; // mapping replaced by this instruction
        word_t     src_a;
        word_t     src_b;
    } issue_t;

    typedef struct packed {
        logic      valid;
        arch_idx_t arch_rd;
        phys_idx_t phys_rd;
        phys_idx_t old_phys_rd;
        word_t     value;
    } unit_result_t;

    typedef struct packed {
        logic      we;
        phys_idx_t phys_rd;
        word_t     value;
    } wb_t;

    typedef struct packed {
        logic      valid;
        arch_idx_t arch_rd;
        word_t     value;
    } retire_t;

endpackage

`default_nettype wire

//--- design/rename_decode.sv
`timescale 1ns/1ns
`default_nettype none

module rename_decode (
    input  logic                clk,
    input  logic                reset,
    input  prf_pkg::instr_u     instr,
    input  logic                instr_valid,
    output logic                instr_ready,
    output prf_pkg::phys_idx_t  rd_idx_a,
    output prf_pkg::phys_idx_t  rd_idx_b,
    input  prf_pkg::word_t      rd_data_a,
    input  prf_pkg::word_t      rd_data_b,
    input  logic                rd_valid_a,
    input  logic                rd_valid_b,
    output logic                alloc_en,
    output prf_pkg::phys_idx_t  alloc_idx,
    input  logic                free_add_en,
    input  prf_pkg::phys_idx_t  free_add_idx,
    input  logic                free_mul_en,
    input  prf_pkg::phys_idx_t  free_mul_idx,
    output prf_pkg::issue_t     issue,
    output logic                issue_valid
);

    prf_pkg::phys_idx_t map_q [prf_pkg::num_arch_regs];
    prf_pkg::phys_idx_t free_q [prf_pkg::free_depth];
    prf_pkg::free_ptr_t head_q;
    prf_pkg::free_ptr_t tail_q;
    prf_pkg::free_ptr_t count_q;

    prf_pkg::arch_idx_t rd;
    prf_pkg::word_t     imm_ext;
    logic               is_mul;
    logic               is_imm;
    logic               src_ok;
    logic               tag_ok;
    logic               accept;
    logic [1:0]         n_free;

    // circular pointer step, wraps at the queue depth
    function automatic prf_pkg::free_ptr_t ptr_add(prf_pkg::free_ptr_t ptr, logic [1:0] step);
        logic [7:0] sum;
        sum = 8'(ptr) + 8'(step);
        if (sum >= 8'(prf_pkg::free_depth)) begin
            sum = sum - 8'(prf_pkg::free_depth);
        end
        return prf_pkg::free_ptr_t'(sum);
    endfunction

    assign rd      = instr.r.rd;
    assign is_mul  = (instr.r.opcode == prf_pkg::op_mul);
    assign is_imm  = (instr.r.opcode == prf_pkg::op_addi);
    assign imm_ext = {{14{instr.i.imm[17]}}, instr.i.imm}; // sign extend

    assign rd_idx_a = map_q[instr.r.rs1];
    assign rd_idx_b = map_q[instr.r.rs2]; // ignored for addi

    assign src_ok      = rd_valid_a && (is_imm || rd_valid_b);
    assign tag_ok      = (rd == '0) || (count_q != '0);
    assign instr_ready = !instr_valid || (src_ok && tag_ok);
    assign accept      = instr_valid && instr_ready;

    assign alloc_en  = accept && (rd != '0); // x0 never takes a tag
    assign alloc_idx = free_q[head_q];
    assign n_free    = {1'b0, free_add_en} + {1'b0, free_mul_en};

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < prf_pkg::num_arch_regs; i++) begin
                map_q[i] <= prf_pkg::phys_idx_t'(i); // identity mapping
            end
        end else if (alloc_en) begin
            map_q[rd] <= alloc_idx;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < prf_pkg::free_depth; i++) begin
                free_q[i] <= prf_pkg::phys_idx_t'(i + prf_pkg::num_arch_regs);
            end
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= prf_pkg::free_ptr_t'(prf_pkg::free_depth); // full
        end else begin
            if (free_add_en) begin
                free_q[tail_q] <= free_add_idx;
            end
            if (free_mul_en) begin
                free_q[free_add_en ? ptr_add(tail_q, 2'd1) : tail_q] <= free_mul_idx;
            end
            if (alloc_en) begin
                head_q <= ptr_add(head_q, 2'd1);
            end
            tail_q  <= ptr_add(tail_q, n_free);
            count_q <= count_q + prf_pkg::free_ptr_t'(n_free)
                       - prf_pkg::free_ptr_t'(alloc_en);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            issue.unit_mul    <= is_mul;
            issue.arch_rd     <= rd;
            issue.phys_rd     <= alloc_en ? alloc_idx : '0;
            issue.old_phys_rd <= map_q[rd];
            issue.src_a       <= rd_data_a;
            issue.src_b       <= is_imm ? imm_ext : rd_data_b;
        end
    end

endmodule

`default_nettype wire

//--- design/phys_reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module phys_reg_file (
    input  logic               clk,
    input  logic               reset,
    input  prf_pkg::phys_idx_t rd_idx_a,
    input  prf_pkg::phys_idx_t rd_idx_b,
    output prf_pkg::word_t     rd_data_a,
    output prf_pkg::word_t     rd_data_b,
    output logic               rd_valid_a,
    output logic               rd_valid_b,
    input  logic               alloc_en,
    input  prf_pkg::phys_idx_t alloc_idx,
    input  prf_pkg::wb_t       wb_add,
    input  prf_pkg::wb_t       wb_mul
);

    prf_pkg::word_t                    data_q [prf_pkg::num_phys_regs];
    logic [prf_pkg::num_phys_regs-1:0] valid_q;

    logic wr_add;
    logic wr_mul;

    // entry 0 is hardwired, never stored to
    assign wr_add = wb_add.we && (wb_add.phys_rd != '0);
    assign wr_mul = wb_mul.we && (wb_mul.phys_rd != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < prf_pkg::num_phys_regs; i++) begin
                if (i < prf_pkg::num_arch_regs) begin
                    data_q[i]  <= prf_pkg::word_t'(i); // arch reg i starts with value i
                    valid_q[i] <= 1'b1;
                end else begin
                    data_q[i]  <= '0;
                    valid_q[i] <= 1'b0;
                end
            end
        end else begin
            // rename clears the new tag until its producer writes back
            if (alloc_en && (alloc_idx != '0)) begin
                valid_q[alloc_idx] <= 1'b0;
            end
            if (wr_add) begin
                data_q[wb_add.phys_rd]  <= wb_add.value;
                valid_q[wb_add.phys_rd] <= 1'b1;
            end
            if (wr_mul) begin
                data_q[wb_mul.phys_rd]  <= wb_mul.value;
                valid_q[wb_mul.phys_rd] <= 1'b1;
            end
        end
    end

    // combinational read, x0 reads zero and ready
    always_comb begin
        if (rd_idx_a == '0) begin
            rd_data_a  = '0;
            rd_valid_a = 1'b1;
        end else begin
            rd_data_a  = data_q[rd_idx_a];
            rd_valid_a = valid_q[rd_idx_a];
        end
    end

    always_comb begin
        if (rd_idx_b == '0) begin
            rd_data_b  = '0;
            rd_valid_b = 1'b1;
        end else begin
            rd_data_b  = data_q[rd_idx_b];
            rd_valid_b = valid_q[rd_idx_b];
        end
    end

endmodule

`default_nettype wire

//--- design/exec_units.sv
`timescale 1ns/1ns
`default_nettype none

module exec_units (
    input  logic                  clk,
    input  logic                  reset,
    input  prf_pkg::issue_t       issue,
    input  logic                  issue_valid,
    output prf_pkg::unit_result_t add_res,
    output prf_pkg::unit_result_t mul_res
);

    localparam int last = prf_pkg::mul_latency - 1;

    logic fire_add;
    logic fire_mul;

    prf_pkg::issue_t       mul_op_q;   // operand latch ahead of the product pipe
    logic                  mul_op_vld_q;
    prf_pkg::word_t        mul_lo;
    prf_pkg::unit_result_t mul_pipe_q [prf_pkg::mul_latency];

    assign fire_add = issue_valid && !issue.unit_mul;
    assign fire_mul = issue_valid && issue.unit_mul;

    // single cycle adder, wraps at 32 bits
    always_ff @(posedge clk) begin
        if (reset) begin
            add_res.valid <= 1'b0;
        end else begin
            add_res.valid <= fire_add;
            if (fire_add) begin
                add_res.arch_rd     <= issue.arch_rd;
                add_res.phys_rd     <= issue.phys_rd;
                add_res.old_phys_rd <= issue.old_phys_rd;
                add_res.value       <= issue.src_a + issue.src_b;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mul_op_vld_q <= 1'b0;
        end else begin
            mul_op_vld_q <= fire_mul;
            if (fire_mul) begin
                mul_op_q <= issue;
            end
        end
    end

    assign mul_lo = mul_op_q.src_a * mul_op_q.src_b; // low half of the product

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < prf_pkg::mul_latency; s++) begin
                mul_pipe_q[s].valid <= 1'b0;
            end
        end else begin
            mul_pipe_q[0].valid       <= mul_op_vld_q;
            mul_pipe_q[0].arch_rd     <= mul_op_q.arch_rd;
            mul_pipe_q[0].phys_rd     <= mul_op_q.phys_rd;
            mul_pipe_q[0].old_phys_rd <= mul_op_q.old_phys_rd;
            mul_pipe_q[0].value       <= mul_lo;
            for (int s = 1; s < prf_pkg::mul_latency; s++) begin
                mul_pipe_q[s] <= mul_pipe_q[s-1]; // one op per stage
            end
        end
    end

    assign mul_res = mul_pipe_q[last];

endmodule

`default_nettype wire

//--- design/retire_result.sv
`timescale 1ns/1ns
`default_nettype none

module retire_result (
    input  logic                  clk,
    input  logic                  reset,
    input  prf_pkg::unit_result_t add_res,
    input  prf_pkg::unit_result_t mul_res,
    output prf_pkg::wb_t          wb_add,
    output prf_pkg::wb_t          wb_mul,
    output logic                  free_add_en,
    output prf_pkg::phys_idx_t    free_add_idx,
    output logic                  free_mul_en,
    output prf_pkg::phys_idx_t    free_mul_idx,
    output prf_pkg::retire_t      retire_add,
    output prf_pkg::retire_t      retire_mul
);

    // lane 0 is the adder, lane 1 the multiplier
    prf_pkg::unit_result_t res [2];
    prf_pkg::wb_t          wb [2];
    logic [1:0]            keep;
    prf_pkg::retire_t      rt_q [2];
    logic [1:0]            free_en_q;
    prf_pkg::phys_idx_t    free_idx_q [2];

    assign res[0] = add_res;
    assign res[1] = mul_res;

    always_comb begin
        for (int l = 0; l < 2; l++) begin
            keep[l]       = res[l].valid && (res[l].arch_rd != '0); // x0 writes nothing
            wb[l].we      = keep[l];
            wb[l].phys_rd = res[l].phys_rd;
            wb[l].value   = res[l].value;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int l = 0; l < 2; l++) begin
                rt_q[l].valid <= 1'b0;
                free_en_q[l]  <= 1'b0;
            end
        end else begin
            for (int l = 0; l < 2; l++) begin
                rt_q[l].valid   <= res[l].valid;
                rt_q[l].arch_rd <= res[l].arch_rd;
                rt_q[l].value   <= (res[l].arch_rd == '0) ? '0 : res[l].value;
                free_en_q[l]    <= keep[l];            // release the replaced tag
                free_idx_q[l]   <= res[l].old_phys_rd;
            end
        end
    end

    // register file write lands on the same edge as the retire register
    assign wb_add = wb[0];
    assign wb_mul = wb[1];

    assign free_add_en  = free_en_q[0];
    assign free_add_idx = free_idx_q[0];
    assign free_mul_en  = free_en_q[1];
    assign free_mul_idx = free_idx_q[1];

    assign retire_add = rt_q[0];
    assign retire_mul = rt_q[1];

endmodule

`default_nettype wire

//--- design/ooo_core_top.sv
`timescale 1ns/1ns
`default_nettype none

module ooo_core_top (
    input  logic             clk,
    input  logic             reset,
    input  prf_pkg::instr_u  instr,
    input  logic             instr_valid,
    output logic             instr_ready,
    output prf_pkg::retire_t retire_add,
    output prf_pkg::retire_t retire_mul
);

    prf_pkg::phys_idx_t    rd_idx_a;
    prf_pkg::phys_idx_t    rd_idx_b;
    prf_pkg::word_t        rd_data_a;
    prf_pkg::word_t        rd_data_b;
    logic                  rd_valid_a;
    logic                  rd_valid_b;
    logic                  alloc_en;
    prf_pkg::phys_idx_t    alloc_idx;
    logic                  free_add_en;
    prf_pkg::phys_idx_t    free_add_idx;
    logic                  free_mul_en;
    prf_pkg::phys_idx_t    free_mul_idx;
    prf_pkg::issue_t       issue;
    logic                  issue_valid;
    prf_pkg::unit_result_t add_res;
    prf_pkg::unit_result_t mul_res;
    prf_pkg::wb_t          wb_add;
    prf_pkg::wb_t          wb_mul;

    rename_decode u_rename_decode (
        .clk          (clk),
        .reset        (reset),
        .instr        (instr),
        .instr_valid  (instr_valid),
        .instr_ready  (instr_ready),
        .rd_idx_a     (rd_idx_a),
        .rd_idx_b     (rd_idx_b),
        .rd_data_a    (rd_data_a),
        .rd_data_b    (rd_data_b),
        .rd_valid_a   (rd_valid_a),
        .rd_valid_b   (rd_valid_b),
        .alloc_en     (alloc_en),
        .alloc_idx    (alloc_idx),
        .free_add_en  (free_add_en),
        .free_add_idx (free_add_idx),
        .free_mul_en  (free_mul_en),
        .free_mul_idx (free_mul_idx),
        .issue        (issue),
        .issue_valid  (issue_valid)
    );

    phys_reg_file u_phys_reg_file (
        .clk        (clk),
        .reset      (reset),
        .rd_idx_a   (rd_idx_a),
        .rd_idx_b   (rd_idx_b),
        .rd_data_a  (rd_data_a),
        .rd_data_b  (rd_data_b),
        .rd_valid_a (rd_valid_a),
        .rd_valid_b (rd_valid_b),
        .alloc_en   (alloc_en),
        .alloc_idx  (alloc_idx),
        .wb_add     (wb_add),
        .wb_mul     (wb_mul)
    );

    exec_units u_exec_units (
        .clk         (clk),
        .reset       (reset),
        .issue       (issue),
        .issue_valid (issue_valid),
        .add_res     (add_res),
        .mul_res     (mul_res)
    );

    retire_result u_retire_result (
        .clk          (clk),
        .reset        (reset),
        .add_res      (add_res),
        .mul_res      (mul_res),
        .wb_add       (wb_add),
        .wb_mul       (wb_mul),
        .free_add_en  (free_add_en),
        .free_add_idx (free_add_idx),
        .free_mul_en  (free_mul_en),
        .free_mul_idx (free_mul_idx),
        .retire_add   (retire_add),
        .retire_mul   (retire_mul)
    );

endmodule

`default_nettype wire

//--- dv/tb_tests.svh
    // each test starts and ends on a falling edge

    task automatic test_reset_state();
        logic rdy;
        int   acc;
        test_name = "reset_state";
        check_ready(test_name, 1'b1, instr_ready); // nothing presented yet
        check_ready(test_name, 1'b0, retire_add.valid);
        check_ready(test_name, 1'b0, retire_mul.valid);
        for (int k = 1; k < 8; k++) begin
            send(make_i(5'(k), 5'(k), 18'sd0), rdy, acc); // xk still holds k
        end
        send(make_r(prf_pkg::op_add, 5'd9, 5'd0, 5'd0), rdy, acc); // x0 reads zero
        drain();
    endtask

    task automatic test_dependency();
        logic rdy;
        int   acc;
        int   prev;
        test_name = "dependency_chain";
        send(make_i(5'd10, 5'd3, 18'sd7), rdy, prev);
        for (int n = 0; n < 9; n++) begin
            send(make_r(prf_pkg::op_add, 5'd10, 5'd10, 5'd2), rdy, acc); // needs last x10
            check_ready(test_name, 1'b0, rdy);
            check_at_least(test_name, 3, acc - prev); // accept gap sets the retire gap
            prev = acc;
        end
        drain();
    endtask

    task automatic test_mul_latency();
        logic rdy;
        int   mul_acc;
        int   add_acc;
        test_name = "mul_then_add";
        send(make_r(prf_pkg::op_mul, 5'd12, 5'd3, 5'd5), rdy, mul_acc);
        send(make_r(prf_pkg::op_add, 5'd13, 5'd4, 5'd6), rdy, add_acc);
        drain();
        check_at_least(test_name, 1, last_mul_retire - last_add_retire); // add lane first

        // product feeding an add holds the add back
        test_name = "mul_to_add";
        send(make_r(prf_pkg::op_mul, 5'd14, 5'd12, 5'd13), rdy, mul_acc);
        send(make_r(prf_pkg::op_add, 5'd15, 5'd14, 5'd1), rdy, add_acc);
        check_ready(test_name, 1'b0, rdy);
        check_at_least(test_name, 3 + prf_pkg::mul_latency, add_acc - mul_acc);
        drain();
    endtask

    task automatic test_reg_zero();
        logic rdy;
        int   acc;
        test_name = "reg_zero";
        send(make_r(prf_pkg::op_add, 5'd0, 5'd7, 5'd8), rdy, acc);
        send(make_r(prf_pkg::op_mul, 5'd0, 5'd7, 5'd8), rdy, acc);
        send(make_i(5'd0, 5'd7, 18'sd100), rdy, acc);
        send(make_r(prf_pkg::op_add, 5'd16, 5'd0, 5'd7), rdy, acc); // x0 still zero
        send(make_r(prf_pkg::op_mul, 5'd17, 5'd0, 5'd9), rdy, acc);
        drain();
    endtask

    task automatic test_tag_recycle();
        logic               rdy;
        int                 acc;
        logic [31:0]        r;
        logic [31:0]        imm_bits;
        prf_pkg::arch_idx_t rd;
        prf_pkg::arch_idx_t rs1;
        prf_pkg::arch_idx_t rs2;
        prf_pkg::arch_idx_t last_rd;
        test_name = "tag_recycle";
        last_rd   = 5'd1;
        for (int n = 0; n < 300; n++) begin
            r        = next_random();
            imm_bits = next_random();
            rd       = r[31:27];
            rs1      = r[26] ? last_rd : r[25:21]; // about half chain on the last result
            rs2      = r[20] ? last_rd : r[19:15];
            case (r[14:13])
                2'd1:    send(make_i(rd, rs1, imm_bits[17:0]), rdy, acc);
                2'd2:    send(make_r(prf_pkg::op_mul, rd, rs1, rs2), rdy, acc);
                default: send(make_r(prf_pkg::op_add, rd, rs1, rs2), rdy, acc);
            endcase
            last_rd = rd;
        end
        drain();
    endtask

    task automatic test_handshake_hold();
        logic rdy;
        int   acc;
        test_name = "handshake_hold";
        send(make_r(prf_pkg::op_mul, 5'd20, 5'd4, 5'd4), rdy, acc);
        send(make_r(prf_pkg::op_add, 5'd21, 5'd20, 5'd20), rdy, acc); // held for the product
        check_ready(test_name, 1'b0, rdy);
        send(make_i(5'd22, 5'd21, -18'sd5), rdy, acc);
        check_ready(test_name, 1'b0, rdy);
        send(make_r(prf_pkg::op_add, 5'd23, 5'd22, 5'd0), rdy, acc);
        send(make_r(prf_pkg::op_mul, 5'd24, 5'd23, 5'd23), rdy, acc);
        send(make_i(5'd25, 5'd24, 18'sd1), rdy, acc);
        drain();
    endtask

//--- dv/tb_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_top;

    localparam int clk_half     = 2;
    localparam int reset_cycles = 8;
    localparam int num_instrs   = 8 + 10 + 4 + 5 + 300 + 6; // summed over all tests
    localparam int limit_cycles = num_instrs * (prf_pkg::mul_latency + 4) + reset_cycles;

    logic             clk;
    logic             reset;
    prf_pkg::instr_u  instr;
    logic             instr_valid;
    logic             instr_ready;
    prf_pkg::retire_t retire_add;
    prf_pkg::retire_t retire_mul;

    int               cycle = 0;
    int               last_add_retire;
    int               last_mul_retire;
    logic [31:0]      lcg_state;
    string            test_name;
    prf_pkg::word_t   arch_val [prf_pkg::num_arch_regs]; // architectural values in order
    prf_pkg::retire_t add_exp_q [$];
    prf_pkg::retire_t mul_exp_q [$];
    int               add_due_q [$]; // edge index each result must retire on
    int               mul_due_q [$];

    ooo_core_top u_dut (
        .clk         (clk),
        .reset       (reset),
        .instr       (instr),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .retire_add  (retire_add),
        .retire_mul  (retire_mul)
    );

    initial begin
        clk = 1'b0;
        forever #clk_half clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1; // rising edge count
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic prf_pkg::instr_u make_r(prf_pkg::opcode_e op, prf_pkg::arch_idx_t rd,
                                               prf_pkg::arch_idx_t rs1,
                                               prf_pkg::arch_idx_t rs2);
        prf_pkg::instr_u ins;
        ins          = '0;
        ins.r.opcode = op;
        ins.r.rd     = rd;
        ins.r.rs1    = rs1;
        ins.r.rs2    = rs2;
        return ins;
    endfunction

    function automatic prf_pkg::instr_u make_i(prf_pkg::arch_idx_t rd, prf_pkg::arch_idx_t rs1,
                                               logic signed [17:0] imm);
        prf_pkg::instr_u ins;
        ins          = '0;
        ins.i.opcode = prf_pkg::op_addi;
        ins.i.rd     = rd;
        ins.i.rs1    = rs1;
        ins.i.imm    = imm;
        return ins;
    endfunction

    // result of one instruction against the architectural values
    function automatic prf_pkg::word_t model_exec(prf_pkg::instr_u ins);
        prf_pkg::word_t a;
        prf_pkg::word_t b;
        prf_pkg::word_t imm;
        a   = arch_val[ins.r.rs1];
        b   = arch_val[ins.r.rs2];
        imm = {{14{ins.i.imm[17]}}, ins.i.imm};
        case (ins.r.opcode)
            prf_pkg::op_addi: return a + imm;
            prf_pkg::op_mul:  return a * b; // low 32 bits
            default:          return a + b;
        endcase
    endfunction

    task automatic check_retire(input string name, input prf_pkg::retire_t want,
                                input prf_pkg::retire_t got);
        if (want !== got) begin
            $display("Mismatch in %s: expected rd=%0d value=%h, actual rd=%0d value=%h",
                     name, want.arch_rd, want.value, got.arch_rd, got.value);
            $display("TEST FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_ready(input string name, input logic want, input logic got);
        if (want !== got) begin
            $display("Mismatch in %s: expected flag %b, actual %b", name, want, got);
            $display("TEST FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_count(input string name, input int want, input int got);
        if (want != got) begin
            $display("Mismatch in %s: expected %0d, actual %0d", name, want, got);
            $display("TEST FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_at_least(input string name, input int floor, input int got);
        if (got < floor) begin
            $display("Mismatch in %s: expected at least %0d, actual %0d", name, floor, got);
            $display("TEST FAIL");
            $fatal(1);
        end
    endtask

    // hold one instruction on the input until the DUT takes it
    task automatic send(input prf_pkg::instr_u ins, output logic first_ready,
                        output int accept_cycle);
        prf_pkg::retire_t want;
        logic             taken;
        want.valid   = 1'b1;
        want.arch_rd = ins.r.rd;
        want.value   = (ins.r.rd == '0) ? '0 : model_exec(ins); // x0 retires zero
        if (ins.r.rd != '0) begin
            arch_val[ins.r.rd] = want.value;
        end
        instr       = ins;
        instr_valid = 1'b1;
        #1;
        first_ready = instr_ready;
        taken       = instr_ready;
        @(negedge clk);
        while (!taken) begin
            #1;
            taken = instr_ready; // held stable until accepted
            @(negedge clk);
        end
        instr_valid  = 1'b0;
        accept_cycle = cycle;
        if (ins.r.opcode == prf_pkg::op_mul) begin
            mul_exp_q.push_back(want);
            mul_due_q.push_back(accept_cycle + 2 + prf_pkg::mul_latency);
        end else begin
            add_exp_q.push_back(want);
            add_due_q.push_back(accept_cycle + 2);
        end
    endtask

    // wait for all outstanding retires and a quiet spell after them
    task automatic drain();
        while (add_exp_q.size() != 0 || mul_exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (prf_pkg::mul_latency + 2) @(negedge clk);
    endtask

    always @(negedge clk) begin
        if (!reset && retire_add.valid) begin
            if (add_exp_q.size() == 0) begin
                $display("Retire on the add lane in %s with no instruction outstanding",
                         test_name);
                $display("TEST FAIL");
                $fatal(1);
            end else begin
                check_retire(test_name, add_exp_q.pop_front(), retire_add);
                check_count({test_name, " add latency"}, add_due_q.pop_front(), cycle);
                last_add_retire = cycle;
            end
        end
        if (!reset && retire_mul.valid) begin
            if (mul_exp_q.size() == 0) begin
                $display("Retire on the mul lane in %s with no instruction outstanding",
                         test_name);
                $display("TEST FAIL");
                $fatal(1);
            end else begin
                check_retire(test_name, mul_exp_q.pop_front(), retire_mul);
                check_count({test_name, " mul latency"}, mul_due_q.pop_front(), cycle);
                last_mul_retire = cycle;
            end
        end
    end

    initial begin
        repeat (limit_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles without the tests finishing",
                 limit_cycles);
        $display("TEST FAIL");
        $fatal(1);
    end

    `include "tb_tests.svh"

    initial begin
        instr       = '0;
        instr_valid = 1'b0;
        reset       = 1'b1;
        test_name   = "reset";
        lcg_state   = 32'heae1b3d6;
        for (int i = 0; i < prf_pkg::num_arch_regs; i++) begin
            arch_val[i] = prf_pkg::word_t'(i); // reset value is the index
        end
        repeat (reset_cycles) @(negedge clk);
        reset = 1'b0;
        test_reset_state();
        test_dependency();
        test_mul_latency();
        test_reg_zero();
        test_tag_recycle();
        test_handshake_hold();
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+dv
design/prf_pkg.sv
design/rename_decode.sv
design/phys_reg_file.sv
design/exec_units.sv
design/retire_result.sv
design/ooo_core_top.sv
dv/tb_top.sv

//--- Bender.yml
package:
  name: ooo_core

sources:
  - design/prf_pkg.sv
  - design/rename_decode.sv
  - design/phys_reg_file.sv
  - design/exec_units.sv
  - design/retire_result.sv
  - design/ooo_core_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tb_top.sv
